/* Makefile */
# Verilator build and run for the store write path

VERILATOR ?= verilator
TOP       ?= store_path_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hdl/st_pkg.sv
hdl/store_fmt.sv
hdl/align_w.sv
hdl/wr_mem.sv
hdl/store_path_top.sv
sim/tb_clkgen.sv
sim/store_path_sva.sv
sim/store_path_tb.sv

/* hdl/align_w.sv */
// width alignment stage
// steers the core word and enables into the memory line lane picked by address
`timescale 1ns/1ps

module align_w import st_pkg::*;
#(
   parameter int IN_P_DW_BYTES  = st_pkg::MEM_P_DW_BYTES,   // memory side
   parameter int OUT_P_DW_BYTES = st_pkg::ST_P_DW_BYTES,    // core side
   parameter int IN_AW          = st_pkg::MEM_AW
)
(
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_wd_valid,
   input  st_word_t  i_wd,
   output logic      o_ln_valid,
   output st_line_t  o_ln
);

   localparam int IN_BYTES  = 1 << IN_P_DW_BYTES;
   localparam int OUT_BYTES = 1 << OUT_P_DW_BYTES;

   logic [OUT_BYTES*8-1:0]   core_dat;
   logic [OUT_BYTES-1:0]     core_be;
   logic [IN_AW-1:0]         addr;
   logic [IN_BYTES*8-1:0]    ln_dat;   // steered line data
   logic [IN_BYTES-1:0]      ln_be;

   assign core_dat = i_wd.dat;
   assign core_be  = i_wd.be;
   assign addr     = i_wd.addr;

   // ~~~~~~~~~~~~~~~~~~~~
   // lane steering
   // ~~~~~~~~~~~~~~~~~~~~
   generate
      if (OUT_P_DW_BYTES == IN_P_DW_BYTES)
      begin : gen_eq
         assign ln_be  = core_be;        // straight through
         assign ln_dat = core_dat;
      end
      else if (OUT_P_DW_BYTES < IN_P_DW_BYTES)
      begin : gen_narrow
         localparam int WIN_NUM   = IN_BYTES / OUT_BYTES;
         localparam int WIN_P_NUM = IN_P_DW_BYTES - OUT_P_DW_BYTES;

         // word copied into every lane, enables only in the addressed one
         for (genvar i = 0; i < WIN_NUM; i++)
         begin : gen_lane
            assign ln_be[i*OUT_BYTES +: OUT_BYTES] =
               {OUT_BYTES{addr[OUT_P_DW_BYTES +: WIN_P_NUM] == i}} & core_be;
            assign ln_dat[i*OUT_BYTES*8 +: OUT_BYTES*8] = core_dat;
         end
      end
      else
      begin : gen_wide
         localparam int WIN_NUM   = OUT_BYTES / IN_BYTES;
         localparam int WIN_P_NUM = OUT_P_DW_BYTES - IN_P_DW_BYTES;

         logic [IN_BYTES*8-1:0] dat_win [WIN_NUM];
         logic [IN_BYTES-1:0]   be_win  [WIN_NUM];

         // cut the core word into line sized windows
         for (genvar i = 0; i < WIN_NUM; i++)
         begin : gen_win
            assign dat_win[i] = core_dat[i*IN_BYTES*8 +: IN_BYTES*8];
            assign be_win[i]  = core_be[i*IN_BYTES +: IN_BYTES];
         end

         // address names the window
         assign ln_be  = be_win[addr[IN_P_DW_BYTES +: WIN_P_NUM]];
         assign ln_dat = dat_win[addr[IN_P_DW_BYTES +: WIN_P_NUM]];
      end
   endgenerate

   // ~~~~~~~~~~~~~~~~~~~~
   // stage register
   // ~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         o_ln_valid <= 1'b0;
      end
      else
      begin
         o_ln_valid <= i_wd_valid;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_wd_valid)
      begin
         o_ln.idx <= addr[IN_AW-1:IN_P_DW_BYTES];   // address above the line offset
         o_ln.be  <= ln_be;
         o_ln.dat <= ln_dat;
      end
   end

endmodule

/* hdl/st_pkg.sv */
// store path package
// access size encoding, width defaults and the payload structs between stages

package st_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // width defaults
   // ~~~~~~~~~~~~~~~~~~~~
   localparam int ST_P_DW_BYTES  = 3;                    // log2 core word bytes, 64-bit
   localparam int MEM_P_DW_BYTES = 4;                    // log2 memory line bytes, 128-bit
   localparam int MEM_AW         = 10;                   // byte address width

   localparam int ST_BYTES  = 1 << ST_P_DW_BYTES;        // 8
   localparam int MEM_BYTES = 1 << MEM_P_DW_BYTES;       // 16
   localparam int LN_IW     = MEM_AW - MEM_P_DW_BYTES;   // line index bits

   // ~~~~~~~~~~~~~~~~~~~~
   // access size
   // ~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [1:0]
   {
      SZ_B = 2'd0,   // 1 byte
      SZ_H = 2'd1,   // 2 bytes
      SZ_W = 2'd2,   // 4 bytes
      SZ_D = 2'd3    // 8 bytes
   } st_size_t;

   // ~~~~~~~~~~~~~~~~~~~~
   // stage payloads
   // ~~~~~~~~~~~~~~~~~~~~

   // request from the core's memory stage
   typedef struct packed
   {
      logic [MEM_AW-1:0]      addr;
      st_size_t               size;
      logic [ST_BYTES*8-1:0]  data;   // register data, low bytes valid
   } st_req_t;

   // formatted core word, stage 1 to stage 2
   typedef struct packed
   {
      logic [MEM_AW-1:0]      addr;
      logic [ST_BYTES-1:0]    be;
      logic [ST_BYTES*8-1:0]  dat;    // replicated store data
   } st_word_t;

   // memory line, stage 2 to stage 3
   typedef struct packed
   {
      logic [LN_IW-1:0]       idx;
      logic [MEM_BYTES-1:0]   be;
      logic [MEM_BYTES*8-1:0] dat;
   } st_line_t;

endpackage

/* hdl/store_fmt.sv */
// store formatting stage
// checks alignment, builds byte enables and replicates store data in the core word
`timescale 1ns/1ps

module store_fmt import st_pkg::*;
#(
   parameter int MEM_AW = st_pkg::MEM_AW
)
(
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_st_valid,
   input  st_req_t   i_st_req,
   output logic      o_wd_valid,
   output st_word_t  o_wd,
   output logic      o_st_err
);

   logic [MEM_AW-1:0]         addr;
   logic [ST_P_DW_BYTES-1:0]  off;     // byte offset in the core word
   logic [ST_BYTES-1:0]       run;     // unshifted enable run
   logic [ST_BYTES-1:0]       be;
   logic [ST_BYTES*8-1:0]     rep;     // replicated data
   logic                      mis;     // misaligned

   assign addr = i_st_req.addr;
   assign off  = addr[ST_P_DW_BYTES-1:0];

   // ~~~~~~~~~~~~~~~~~~~~
   // size decode
   // ~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (i_st_req.size)
         SZ_B:
         begin
            run = 8'h01;
            rep = {8{i_st_req.data[7:0]}};
            mis = 1'b0;                      // bytes never misalign
         end
         SZ_H:
         begin
            run = 8'h03;
            rep = {4{i_st_req.data[15:0]}};
            mis = off[0];
         end
         SZ_W:
         begin
            run = 8'h0f;
            rep = {2{i_st_req.data[31:0]}};
            mis = |off[1:0];
         end
         default:
         begin
            run = 8'hff;                     // full doubleword
            rep = i_st_req.data;
            mis = |off;
         end
      endcase
   end

   assign be = run << off;                  // run lands on the addressed bytes

   // ~~~~~~~~~~~~~~~~~~~~
   // stage register
   // ~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         o_wd_valid <= 1'b0;
         o_st_err   <= 1'b0;
      end
      else
      begin
         o_wd_valid <= i_st_valid & ~mis;   // misaligned store dropped here
         o_st_err   <= i_st_valid & mis;    // one cycle strobe
      end
   end

   // payload, loaded only on a good store
   always_ff @(posedge i_clk)
   begin
      if (i_st_valid && !mis)
      begin
         o_wd.addr <= addr;
         o_wd.be   <= be;
         o_wd.dat  <= rep;
      end
   end

endmodule

/* hdl/store_path_top.sv */
// store write path top
// format, align and line memory stages chained in a 3 stage pipeline
`timescale 1ns/1ps

module store_path_top import st_pkg::*;
#(
   parameter int ST_P_DW_BYTES  = st_pkg::ST_P_DW_BYTES,
   parameter int MEM_P_DW_BYTES = st_pkg::MEM_P_DW_BYTES,
   parameter int MEM_AW         = st_pkg::MEM_AW
)
(
   input  logic                                i_clk,
   input  logic                                i_rst,
   input  logic                                i_st_valid,
   input  st_req_t                             i_st_req,
   output logic                                o_st_err,
   input  logic                                i_rd_valid,
   input  logic [MEM_AW-MEM_P_DW_BYTES-1:0]    i_rd_idx,
   output logic                                o_rd_valid,
   output logic [(1<<MEM_P_DW_BYTES)*8-1:0]    o_rd_line,
   output logic                                o_busy
);

   logic       st_valid;   // strobe outside clearing
   logic       wd_valid;   // stage 1 to 2
   st_word_t   wd;
   logic       ln_valid;   // stage 2 to 3
   st_line_t   ln;

   // stores ignored while the memory clears
   assign st_valid = i_st_valid & ~o_busy;

   // ~~~~~~~~~~~~~~~~~~~~
   // stages
   // ~~~~~~~~~~~~~~~~~~~~
   store_fmt #(
      .MEM_AW         (MEM_AW)
   ) u_fmt (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_st_valid     (st_valid),
      .i_st_req       (i_st_req),
      .o_wd_valid     (wd_valid),
      .o_wd           (wd),
      .o_st_err       (o_st_err)
   );

   align_w #(
      .IN_P_DW_BYTES  (MEM_P_DW_BYTES),   // line side
      .OUT_P_DW_BYTES (ST_P_DW_BYTES),    // core side
      .IN_AW          (MEM_AW)
   ) u_align (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_wd_valid     (wd_valid),
      .i_wd           (wd),
      .o_ln_valid     (ln_valid),
      .o_ln           (ln)
   );

   wr_mem #(
      .MEM_P_DW_BYTES (MEM_P_DW_BYTES),
      .MEM_AW         (MEM_AW)
   ) u_mem (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_ln_valid     (ln_valid),
      .i_ln           (ln),
      .i_rd_valid     (i_rd_valid),
      .i_rd_idx       (i_rd_idx),
      .o_rd_valid     (o_rd_valid),
      .o_rd_line      (o_rd_line),
      .o_busy         (o_busy)
   );

endmodule

/* hdl/wr_mem.sv */
// byte enabled line memory
// per-byte line write, registered read port and clearing after reset
`timescale 1ns/1ps

module wr_mem import st_pkg::*;
#(
   parameter int MEM_P_DW_BYTES = st_pkg::MEM_P_DW_BYTES,
   parameter int MEM_AW         = st_pkg::MEM_AW
)
(
   input  logic                                i_clk,
   input  logic                                i_rst,
   input  logic                                i_ln_valid,
   input  st_line_t                            i_ln,
   input  logic                                i_rd_valid,
   input  logic [MEM_AW-MEM_P_DW_BYTES-1:0]    i_rd_idx,
   output logic                                o_rd_valid,
   output logic [(1<<MEM_P_DW_BYTES)*8-1:0]    o_rd_line,
   output logic                                o_busy
);

   localparam int LINE_BYTES = 1 << MEM_P_DW_BYTES;
   localparam int IW         = MEM_AW - MEM_P_DW_BYTES;
   localparam int DEPTH      = 1 << IW;

   logic [LINE_BYTES*8-1:0]  mem [DEPTH];
   logic [IW-1:0]            clr_idx;    // clearing pointer
   logic                     busy_q;

   assign o_busy = busy_q;

   // ~~~~~~~~~~~~~~~~~~~~
   // clearing control
   // ~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         busy_q  <= 1'b1;
         clr_idx <= '0;
      end
      else
      begin
         if (busy_q)
         begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == IW'(DEPTH-1))
            begin
               busy_q <= 1'b0;            // last line cleared
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // line array
   // ~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk)
   begin
      if (busy_q)
      begin
         mem[clr_idx] <= '0;
      end
      else if (i_ln_valid)
      begin
         for (int b = 0; b < LINE_BYTES; b++)
         begin
            if (i_ln.be[b])
            begin
               mem[i_ln.idx][b*8 +: 8] <= i_ln.dat[b*8 +: 8];   // enabled bytes only
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // read port
   // ~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         o_rd_valid <= 1'b0;
      end
      else
      begin
         o_rd_valid <= i_rd_valid & ~busy_q;   // ignored while clearing
      end
   end

   // old line on a same edge write
   always_ff @(posedge i_clk)
   begin
      if (i_rd_valid)
      begin
         o_rd_line <= mem[i_rd_idx];
      end
   end

endmodule

/* sim/store_path_sva.sv */
// store path assertions
// reset values, read response timing and strobes during clearing
`timescale 1ns/1ps

module store_path_sva
(
   input logic i_clk,
   input logic i_rst,
   input logic i_st_valid,
   input logic i_rd_valid,
   input logic i_st_err,
   input logic i_rd_resp,   // o_rd_valid of the top
   input logic i_busy,
   input logic i_mem_wr     // line valid at the line array
);

   // outputs quiet after a reset cycle
   a_reset_quiet: assert property (@(posedge i_clk) i_rst |=> (!i_st_err && !i_rd_resp))
      else $error("o_st_err or o_rd_valid high after a reset cycle");

   // read answered one cycle after the strobe
   a_rd_follow: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_rd_valid && !i_busy) |=> i_rd_resp)
      else $error("read strobe not answered on the next cycle");

   a_rd_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_rd_valid |=> !i_rd_resp)
      else $error("read response without a read strobe");

   // ~~~~~~~~~~~~~~~~~~~~
   // strobes while clearing
   // ~~~~~~~~~~~~~~~~~~~~
   a_busy_rd: assert property (@(posedge i_clk) disable iff (i_rst)
      i_busy |=> !i_rd_resp)
      else $error("read answered while the memory was clearing");

   a_busy_err: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_st_valid && i_busy) |=> !i_st_err)
      else $error("store strobed while clearing raised o_st_err");

   // a line written now was strobed two edges back
   a_busy_st: assert property (@(posedge i_clk) disable iff (i_rst)
      i_mem_wr |-> !$past(i_st_valid && i_busy, 2))
      else $error("store strobed while clearing reached the line array");

endmodule

bind store_path_top store_path_sva u_sva
(
   .i_clk      (i_clk),
   .i_rst      (i_rst),
   .i_st_valid (i_st_valid),
   .i_rd_valid (i_rd_valid),
   .i_st_err   (o_st_err),
   .i_rd_resp  (o_rd_valid),
   .i_busy     (o_busy),
   .i_mem_wr   (ln_valid)
);

/* sim/store_path_tb.sv */
// store path testbench
// directed tests against a byte array model of the line memory
`timescale 1ns/1ps

module store_path_tb import st_pkg::*;
();

   localparam int NUM_LINES = 1 << LN_IW;
   localparam int MEM_SIZE  = 1 << MEM_AW;

   // ~~~~~~~~~~~~~~~~~~~~
   // run length in cycles
   // ~~~~~~~~~~~~~~~~~~~~
   localparam int T_RESET  = NUM_LINES + 4;     // reset plus clearing
   localparam int T_CLEAR  = NUM_LINES;         // one read per line
   localparam int T_SIZES  = 4 * 4 + 30 * 4;    // backgrounds, then store, wait, read
   localparam int T_MIS    = 5 + 5 * 5;
   localparam int T_B2B    = 10;
   localparam int T_TIMING = 4;
   localparam int T_RAND   = 200 * 4;
   localparam int LIMIT    = T_RESET + T_CLEAR + T_SIZES + T_MIS + T_B2B + T_TIMING
                             + T_RAND + 100;    // plus margin

   logic                    clk;
   logic                    rst;
   logic                    st_valid;
   st_req_t                 st_req;
   logic                    st_err;
   logic                    rd_valid;
   logic [LN_IW-1:0]        rd_idx;
   logic                    rd_out_valid;
   logic [MEM_BYTES*8-1:0]  rd_line;
   logic                    busy;

   logic [7:0]  model [MEM_SIZE];   // reference bytes
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   integer      seed;

   tb_clkgen #(.PERIOD_NS(100)) u_clk (.o_clk(clk));

   store_path_top #(
      .ST_P_DW_BYTES  (ST_P_DW_BYTES),
      .MEM_P_DW_BYTES (MEM_P_DW_BYTES),
      .MEM_AW         (MEM_AW)
   ) dut0 (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_st_valid     (st_valid),
      .i_st_req       (st_req),
      .o_st_err       (st_err),
      .i_rd_valid     (rd_valid),
      .i_rd_idx       (rd_idx),
      .o_rd_valid     (rd_out_valid),
      .o_rd_line      (rd_line),
      .o_busy         (busy)
   );

   // watchdog
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // model and helpers
   // ~~~~~~~~~~~~~~~~~~~~
   task automatic next_edge();
      @(posedge clk);
      #1;                                   // drive and sample after the edge
   endtask

   // let the last strobed store reach the array
   task automatic wait_write();
      next_edge();
      next_edge();
   endtask

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   function automatic logic aligned(input logic [MEM_AW-1:0] addr, input st_size_t size);
      int n;
      n = 1 << int'(size);
      return (int'(addr) % n) == 0;         // address a multiple of the size
   endfunction

   // little endian, low data bytes first
   task automatic model_store(input logic [MEM_AW-1:0] addr, input st_size_t size,
                              input logic [63:0] data);
      int n;
      n = 1 << int'(size);
      for (int i = 0; i < n; i++)
      begin
         model[int'(addr) + i] = data[i*8 +: 8];
      end
   endtask

   function automatic logic [MEM_BYTES*8-1:0] model_line(input int idx);
      logic [MEM_BYTES*8-1:0] ln;
      for (int b = 0; b < MEM_BYTES; b++)
      begin
         ln[b*8 +: 8] = model[idx*MEM_BYTES + b];
      end
      return ln;
   endfunction

   // one cycle store strobe, err checked on the next edge
   task automatic drive_store(input logic [MEM_AW-1:0] addr, input st_size_t size,
                              input logic [63:0] data);
      logic mis;
      mis         = !aligned(addr, size);
      st_valid    = 1'b1;
      st_req.addr = addr;
      st_req.size = size;
      st_req.data = data;
      if (!mis)
      begin
         model_store(addr, size, data);
      end
      next_edge();
      st_valid = 1'b0;
      checks++;
      assert (st_err == mis)
      else
      begin
         errors++;
         $display("error %0t: store 0x%03h size %0d gave o_st_err %0b", $time, addr,
                  size, st_err);
      end
   endtask

   task automatic read_expect(input int idx, input logic [MEM_BYTES*8-1:0] exp);
      rd_valid = 1'b1;
      rd_idx   = LN_IW'(idx);
      next_edge();
      rd_valid = 1'b0;
      checks++;
      assert (rd_out_valid)
      else
      begin
         errors++;
         $display("error %0t: no read response for line %0d", $time, idx);
      end
      checks++;
      assert (rd_line == exp)
      else
      begin
         errors++;
         $display("error %0t: line %0d read %032h expected %032h", $time, idx, rd_line, exp);
      end
   endtask

   task automatic read_check(input int idx);
      read_expect(idx, model_line(idx));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // tests
   // ~~~~~~~~~~~~~~~~~~~~

   // stores, bad stores and reads strobed on every clearing cycle, all ignored
   task automatic strobe_while_busy();
      int n;
      n = 0;
      checks++;
      assert (busy)
      else
      begin
         errors++;
         $display("error %0t: o_busy low right after reset", $time);
      end
      while (busy)
      begin
         st_valid    = 1'b1;
         st_req.addr = MEM_AW'(n[0]);         // odd cycles misaligned
         st_req.size = n[0] ? SZ_H : SZ_D;
         st_req.data = '1;
         rd_valid    = 1'b1;
         rd_idx      = '0;
         next_edge();
         st_valid = 1'b0;
         rd_valid = 1'b0;
         n++;
         checks++;
         assert (!rd_out_valid && !st_err)
         else
         begin
            errors++;
            $display("error %0t: strobe while clearing gave o_rd_valid %0b o_st_err %0b",
                     $time, rd_out_valid, st_err);
         end
      end
      checks++;
      assert (n == NUM_LINES)
      else
      begin
         errors++;
         $display("error %0t: o_busy high for %0d cycles expected %0d", $time, n,
                  NUM_LINES);
      end
   endtask

   task automatic test_clear();
      for (int i = 0; i < NUM_LINES; i++)
      begin
         read_check(i);                     // model still all zero
      end
   endtask

   task automatic test_sizes();
      int                n;
      logic [MEM_AW-1:0] base;
      logic [MEM_AW-1:0] addr;
      for (int s = 0; s < 4; s++)
      begin
         base = MEM_AW'((20 + s) * MEM_BYTES);
         drive_store(base, SZ_D, rand64());              // background, lane 0
         drive_store(base + MEM_AW'(8), SZ_D, rand64()); // lane 1
         wait_write();
         n = 1 << s;
         for (int off = 0; off < MEM_BYTES; off += n)
         begin
            addr = base + MEM_AW'(off);
            drive_store(addr, st_size_t'(s), rand64());
            wait_write();
            read_check(20 + s);             // untouched bytes must survive
         end
      end
   endtask

   task automatic bad_store(input logic [MEM_AW-1:0] addr, input st_size_t size);
      drive_store(addr, size, rand64());    // err expected here
      next_edge();
      checks++;
      assert (!st_err)
      else
      begin
         errors++;
         $display("error %0t: o_st_err held past one cycle", $time);
      end
      next_edge();
      read_check(int'(addr >> MEM_P_DW_BYTES));
   endtask

   task automatic test_misalign();
      drive_store(MEM_AW'('h300), SZ_D, rand64());
      drive_store(MEM_AW'('h308), SZ_D, rand64());
      wait_write();
      read_check(48);
      bad_store(MEM_AW'('h301), SZ_H);
      bad_store(MEM_AW'('h30f), SZ_H);
      bad_store(MEM_AW'('h302), SZ_W);      // word at offset 2
      bad_store(MEM_AW'('h30a), SZ_W);
      bad_store(MEM_AW'('h304), SZ_D);
   endtask

   // stores every cycle, later ones overwrite byte by byte
   task automatic test_back_to_back();
      drive_store(MEM_AW'('h280), SZ_D, 64'h0123_4567_89ab_cdef);
      drive_store(MEM_AW'('h288), SZ_D, 64'hfedc_ba98_7654_3210);
      drive_store(MEM_AW'('h283), SZ_B, 64'h0000_0000_0000_005a);
      drive_store(MEM_AW'('h28c), SZ_W, 64'h0000_0000_c0de_f00d);
      drive_store(MEM_AW'('h290), SZ_D, 64'h1111_2222_3333_4444);
      drive_store(MEM_AW'('h282), SZ_H, 64'h0000_0000_0000_a5a5);
      wait_write();
      read_check(40);
      read_check(41);
   endtask

   task automatic test_read_timing();
      logic [MEM_BYTES*8-1:0] old_ln;
      old_ln = model_line(50);
      drive_store(MEM_AW'('h328), SZ_W, 64'h0000_0000_beef_cafe);
      next_edge();
      read_expect(50, old_ln);              // sampled on the write edge
      read_check(50);                       // 3 edges after the store
   endtask

   task automatic test_random();
      st_size_t          size;
      logic [MEM_AW-1:0] addr;
      for (int i = 0; i < 200; i++)
      begin
         size = st_size_t'($random(seed) & 3);
         addr = MEM_AW'($random(seed));
         addr = addr & ~MEM_AW'((1 << int'(size)) - 1);   // force alignment
         drive_store(addr, size, rand64());
         wait_write();
         read_check(int'(addr >> MEM_P_DW_BYTES));
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // main sequence
   // ~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      seed     = 32'h7ac1_6211;
      rst      = 1'b1;
      st_valid = 1'b0;
      st_req   = '0;
      rd_valid = 1'b0;
      rd_idx   = '0;
      for (int i = 0; i < MEM_SIZE; i++)
      begin
         model[i] = 8'h00;                  // memory clears to zero
      end
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      strobe_while_busy();                  // returns once o_busy falls
      test_clear();
      test_sizes();
      test_misalign();
      test_back_to_back();
      test_read_timing();
      test_random();
      next_edge();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* sim/tb_clkgen.sv */
// testbench clock source
// free running clock, low at time zero
`timescale 1ns/1ps

module tb_clkgen
#(
   parameter int PERIOD_NS = 100
)
(
   output logic o_clk
);

   initial
   begin
      o_clk = 1'b0;
      forever
      begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;   // half period toggle
      end
   end

endmodule
